// File: Bender.yml
package:
  name: rx_scheduler

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/sched_pkg.sv
      - hdl/sched_host_regs.sv
      - hdl/slot_keeper.sv
      - hdl/desc_allocator.sv
      - hdl/desc_result.sv
      - hdl/rx_scheduler.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/rx_scheduler_props.sv
      - dv/rx_scheduler_tb.sv

// File: dv/rx_scheduler_props.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module rx_scheduler_props (
  input logic                        clk,
  input logic                        rst_r,
  input logic                        desc_valid,
  input logic                        desc_ready,
  input sched_pkg::if_id_t           desc_if,
  input sched_pkg::core_id_t         desc_core,
  input sched_pkg::slot_t            desc_slot,
  input sched_pkg::hash_t            desc_hash,
  input logic                        desc_drop,
  input logic [`SCHED_IF_COUNT-1:0]  hash_ready
);

  int unsigned fail_count = 0;

  // Output register empty coming out of reset
  a_reset_idle: assert property (@(posedge clk) rst_r |=> !desc_valid)
    else begin
      $error("desc_valid high right after reset");
      fail_count++;
    end

  // A stalled descriptor keeps all its fields
  a_stall_hold: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid && !desc_ready |=> desc_valid && $stable(desc_if) && $stable(desc_core) &&
      $stable(desc_slot) && $stable(desc_hash) && $stable(desc_drop))
    else begin
      $error("descriptor changed while desc_ready was low");
      fail_count++;
    end

  // No beat is taken while the output is stalled
  a_stall_ready: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid && !desc_ready |-> hash_ready == '0)
    else begin
      $error("hash_ready high while the descriptor output was stalled");
      fail_count++;
    end

  a_drop_fields: assert property (@(posedge clk) disable iff (rst_r)
    desc_valid && desc_drop |-> desc_core == '0 && desc_slot == '0)
    else begin
      $error("drop descriptor with a nonzero core or slot");
      fail_count++;
    end

endmodule

bind rx_scheduler rx_scheduler_props props0 (
  .clk         (clk),
  .rst_r       (rst_r),
  .desc_valid  (desc_valid),
  .desc_ready  (desc_ready),
  .desc_if     (desc_if),
  .desc_core   (desc_core),
  .desc_slot   (desc_slot),
  .desc_hash   (desc_hash),
  .desc_drop   (desc_drop),
  .hash_ready  (hash_ready)
);

// File: dv/rx_scheduler_tb.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module rx_scheduler_tb;

  import sched_pkg::*;

  localparam int IFS   = `SCHED_IF_COUNT;
  localparam int CORES = `SCHED_CORE_COUNT;
  localparam int SLOTS = `SCHED_SLOT_COUNT;
  // The sequence runs a few hundred cycles
  localparam int MAX_CYCLES = 2000;

  logic        clk = 1'b0;
  logic        rst_r;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  logic [IFS-1:0] hash_valid;
  hash_t       hash [IFS];
  logic [IFS-1:0] hash_ready;
  line_count_t line_count [IFS];
  logic        slot_msg_valid;
  slot_msg_e   slot_msg_type;
  core_id_t    slot_msg_core;
  slot_t       slot_msg_slot;
  logic        desc_valid;
  logic        desc_ready;
  if_id_t      desc_if;
  core_id_t    desc_core;
  slot_t       desc_slot;
  hash_t       desc_hash;
  logic        desc_drop;

  // Reference model state
  logic [IFS-1:0] taken;
  logic [40:0]    exp_q [$];
  slot_t          pool [CORES][$];
  core_mask_t     en_model;
  core_mask_t     inc_model;
  line_count_t    limit_model;
  int             drop_model [IFS];
  int             last_if;
  int             errors;
  int             checks;
  int             cycle_count;
  logic [31:0]    rng;

  rx_scheduler dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Every falling edge passes through here, so accepted beats get retired
  task automatic step();
    @(negedge clk);
    hash_valid = hash_valid & ~taken;
  endtask

  task automatic idle(input int n);
    repeat (n) step();
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    step();
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    penable = 1'b0;
    step();
    penable = 1'b1;
    step();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_check(input apb_addr_t addr, input apb_data_t exp, input string name);
    step();
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    penable = 1'b0;
    step();
    penable = 1'b1;
    #5;
    check_eq(name, prdata, exp);
    check_eq("pready", pready, 1'b1);
    check_eq("pslverr", pslverr, 1'b0);
    step();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic send_slot_msg(input slot_msg_e kind, input core_id_t core, input slot_t slot);
    step();
    slot_msg_valid = 1'b1;
    slot_msg_type  = kind;
    slot_msg_core  = core;
    slot_msg_slot  = slot;
    step();
    slot_msg_valid = 1'b0;
  endtask

  // Random hash with the core select field forced
  task automatic push_hash(input int i, input core_id_t core);
    rng = xorshift32(rng);
    hash[i] = rng;
    hash[i][`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)] = core;
    hash_valid[i] = 1'b1;
  endtask

  task automatic wait_accepted();
    while (hash_valid != '0) step();
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) step();
  endtask

  // Model follows every clock edge of the DUT
  always @(posedge clk) begin
    int win;
    int idx;
    core_id_t core;
    slot_t slot;
    logic drop;
    logic [40:0] exp;
    taken = hash_valid & hash_ready;
    if (!rst_r) begin
      if (taken != '0) begin
        win = -1;
        for (int k = 1; k <= IFS; k++) begin
          idx = (last_if + k) % IFS;
          if (win < 0 && hash_valid[idx]) win = idx;
        end
        check_eq("hash_ready", taken, 32'(1) << win);
        core = hash[win][`SCHED_HASH_SEL_OFFSET +: $bits(core_id_t)];
        if (inc_model[core] && pool[core].size() != 0) begin
          slot = pool[core].pop_front();
          drop = 1'b0;
        end else begin
          if (line_count[win] < limit_model) begin
            errors++;
            $display("hash on interface %0d was taken although it should have waited", win);
          end
          core = '0;
          slot = '0;
          drop = 1'b1;
          drop_model[win]++;
        end
        exp_q.push_back({drop, if_id_t'(win), core, slot, hash[win]});
        last_if = win;
      end
      if (desc_valid && desc_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a descriptor came out while none was expected");
        end else begin
          exp = exp_q.pop_front();
          check_eq("desc_drop", desc_drop, exp[40]);
          check_eq("desc_if", desc_if, exp[39:38]);
          check_eq("desc_core", desc_core, exp[37:36]);
          check_eq("desc_slot", desc_slot, exp[35:32]);
          check_eq("desc_hash", desc_hash, exp[31:0]);
        end
      end
      if (slot_msg_valid && en_model[slot_msg_core]) begin
        if (slot_msg_type == SLOT_INIT) begin
          pool[slot_msg_core].delete();
          for (int s = 1; s <= slot_msg_slot && s <= SLOTS; s++) begin
            pool[slot_msg_core].push_back(slot_t'(s));
          end
        end else if (pool[slot_msg_core].size() < SLOTS) begin
          pool[slot_msg_core].push_back(slot_msg_slot);
        end
      end
      if (psel && penable && pwrite) begin
        case (paddr)
          `SCHED_ADDR_ENABLE: begin
            inc_model = inc_model & pwdata[CORES-1:0];
            en_model  = pwdata[CORES-1:0];
          end
          `SCHED_ADDR_INCOME:     inc_model = pwdata[CORES-1:0] & en_model;
          `SCHED_ADDR_DROP_LIMIT: limit_model = pwdata[`SCHED_LINES_WIDTH-1:0];
          `SCHED_ADDR_FLUSH: begin
            for (int c = 0; c < CORES; c++) begin
              if (pwdata[c]) pool[c].delete();
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the test sequence did not finish", MAX_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rst_r          = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    hash_valid     = '0;
    slot_msg_valid = 1'b0;
    slot_msg_type  = SLOT_FREE;
    slot_msg_core  = '0;
    slot_msg_slot  = '0;
    desc_ready     = 1'b1;
    for (int i = 0; i < IFS; i++) begin
      hash[i]       = '0;
      line_count[i] = '0;
      drop_model[i] = 0;
    end
    taken       = '0;
    en_model    = '0;
    inc_model   = '0;
    limit_model = `SCHED_DROP_LIMIT_RESET;
    last_if     = IFS - 1;
    errors      = 0;
    checks      = 0;
    rng         = 32'h96b9_27ef;
    idle(8);
    rst_r = 1'b0;

    // Register defaults
    read_check(`SCHED_ADDR_ENABLE, '0, "enabled_cores");
    read_check(`SCHED_ADDR_INCOME, '0, "income_cores");
    read_check(`SCHED_ADDR_DROP_LIMIT, 32'h0E00, "drop_limit");
    for (int c = 0; c < CORES; c++) begin
      read_check(`SCHED_ADDR_SLOT_COUNT_BASE + 4 * c, '0, "slot_count");
    end
    for (int i = 0; i < IFS; i++) begin
      read_check(`SCHED_ADDR_DROP_COUNT_BASE + 4 * i, '0, "drop_count");
    end
    read_check(8'h40, 32'hFEFE_FEFE, "unmapped read");

    // Fill every pool, then allocate
    apb_write(`SCHED_ADDR_ENABLE, 32'hF);
    for (int c = 0; c < CORES; c++) begin
      send_slot_msg(SLOT_INIT, core_id_t'(c), slot_t'(SLOTS));
    end
    apb_write(`SCHED_ADDR_INCOME, 32'hF);
    for (int i = 0; i < IFS; i++) push_hash(i, core_id_t'(i));
    wait_accepted();
    for (int j = 0; j < 3; j++) begin
      push_hash(1, 2'd2);
      wait_accepted();
      read_check(`SCHED_ADDR_SLOT_COUNT_BASE + 8, 32'(pool[2].size()), "slot_count core 2");
    end

    // Closed core holds the hash until the buffer reaches the limit
    apb_write(`SCHED_ADDR_INCOME, 32'hB);
    line_count[1] = 13'd100;
    push_hash(1, 2'd2);
    idle(6);
    #5;
    check_eq("hash_ready", hash_ready, '0);
    check_eq("hash_valid[1] pending", hash_valid[1], 1'b1);
    step();
    line_count[1] = `SCHED_DROP_LIMIT_RESET;
    wait_accepted();
    wait_drained();
    read_check(`SCHED_ADDR_DROP_COUNT_BASE + 4, 32'(drop_model[1]), "drop_count if 1");

    // Income follows the enable mask
    apb_write(`SCHED_ADDR_ENABLE, 32'h7);
    read_check(`SCHED_ADDR_INCOME, 32'h3, "income_cores");
    apb_write(`SCHED_ADDR_INCOME, 32'hF);
    read_check(`SCHED_ADDR_INCOME, 32'h7, "income_cores");

    // Back-pressure on the descriptor output
    desc_ready = 1'b0;
    push_hash(0, 2'd0);
    push_hash(1, 2'd1);
    push_hash(2, 2'd0);
    idle(5);
    #5;
    check_eq("hash_ready", hash_ready, '0);
    check_eq("desc_valid", desc_valid, 1'b1);
    step();
    desc_ready = 1'b1;
    wait_accepted();
    wait_drained();

    // Flush core 0, then freed slots come back in order
    apb_write(`SCHED_ADDR_FLUSH, 32'h1);
    read_check(`SCHED_ADDR_SLOT_COUNT_BASE, '0, "slot_count core 0");
    send_slot_msg(SLOT_FREE, 2'd0, 4'd5);
    send_slot_msg(SLOT_FREE, 2'd0, 4'd3);
    send_slot_msg(SLOT_FREE, 2'd0, 4'd7);
    read_check(`SCHED_ADDR_SLOT_COUNT_BASE, 32'h3, "slot_count core 0");
    for (int j = 0; j < 3; j++) begin
      push_hash(2, 2'd0);
      wait_accepted();
    end
    wait_drained();

    for (int c = 0; c < CORES; c++) begin
      read_check(`SCHED_ADDR_SLOT_COUNT_BASE + 4 * c, 32'(pool[c].size()), "slot_count");
    end
    for (int i = 0; i < IFS; i++) begin
      read_check(`SCHED_ADDR_DROP_COUNT_BASE + 4 * i, 32'(drop_model[i]), "drop_count");
    end
    idle(2);

    $display("checks %0d  errors %0d  assertion failures %0d",
             checks, errors, dut0.props0.fail_count);
    if (errors == 0 && dut0.props0.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: hdl/desc_allocator.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module desc_allocator (
  input  logic                        clk,
  input  logic                        rst_r,
  input  logic [`SCHED_IF_COUNT-1:0]  hash_valid,
  input  sched_pkg::hash_t            hash [`SCHED_IF_COUNT],
  output logic [`SCHED_IF_COUNT-1:0]  hash_ready,
  input  sched_pkg::line_count_t      line_count [`SCHED_IF_COUNT],
  input  logic                        slot_msg_valid,
  input  sched_pkg::slot_msg_e        slot_msg_type,
  input  sched_pkg::core_id_t         slot_msg_core,
  input  sched_pkg::slot_t            slot_msg_slot,
  input  sched_pkg::core_mask_t       enabled_cores,
  input  sched_pkg::core_mask_t       income_cores,
  input  sched_pkg::core_mask_t       slots_flush,
  input  sched_pkg::line_count_t      drop_limit,
  output sched_pkg::slot_t            slot_counts [`SCHED_CORE_COUNT],
  output logic                        alloc_valid,
  output sched_pkg::if_id_t           alloc_if,
  output sched_pkg::core_id_t         alloc_core,
  output sched_pkg::slot_t            alloc_slot,
  output sched_pkg::hash_t            alloc_hash,
  output logic                        alloc_drop,
  input  logic                        alloc_ready
);

  import sched_pkg::*;

  localparam int CORE_W = $bits(core_id_t);

  if_id_t     last_if;
  if_id_t     sel_if;
  logic       sel_found;
  hash_t      sel_hash;
  core_id_t   sel_core;
  logic       can_alloc;
  logic       can_drop;
  logic       take;
  core_mask_t keeper_pop;
  core_mask_t keeper_free;
  core_mask_t keeper_init;
  core_mask_t head_valid;
  slot_t      head_slot [`SCHED_CORE_COUNT];

  // Round robin search starting one past the last winner
  always_comb begin
    int idx;
    sel_found = 1'b0;
    sel_if    = '0;
    for (int k = 1; k <= `SCHED_IF_COUNT; k++) begin
      idx = (int'(last_if) + k) % `SCHED_IF_COUNT;
      if (!sel_found && hash_valid[idx]) begin
        sel_found = 1'b1;
        sel_if    = if_id_t'(idx);
      end
    end
  end

  assign sel_hash = hash[sel_if];
  assign sel_core = sel_hash[`SCHED_HASH_SEL_OFFSET +: CORE_W];

  // Allocate when the core takes traffic, else drop once the buffer is at the limit
  assign can_alloc = income_cores[sel_core] && head_valid[sel_core];
  assign can_drop  = line_count[sel_if] >= drop_limit;

  assign alloc_valid = sel_found && (can_alloc || can_drop);
  assign alloc_if    = sel_if;
  assign alloc_hash  = sel_hash;
  assign alloc_drop  = !can_alloc;
  assign alloc_core  = can_alloc ? sel_core : '0;
  assign alloc_slot  = can_alloc ? head_slot[sel_core] : '0;

  assign take = alloc_valid && alloc_ready;

  always_comb begin
    for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
      hash_ready[i] = take && (sel_if == if_id_t'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      last_if <= if_id_t'(`SCHED_IF_COUNT - 1);
    end else if (take) begin
      last_if <= sel_if;
    end
  end

  for (genvar c = 0; c < `SCHED_CORE_COUNT; c++) begin : g_core
    // Slot messages to a disabled core are ignored
    assign keeper_free[c] = slot_msg_valid && enabled_cores[c] &&
                            (slot_msg_core == core_id_t'(c)) && (slot_msg_type == SLOT_FREE);
    assign keeper_init[c] = slot_msg_valid && enabled_cores[c] &&
                            (slot_msg_core == core_id_t'(c)) && (slot_msg_type == SLOT_INIT);
    assign keeper_pop[c]  = take && can_alloc && (sel_core == core_id_t'(c));

    slot_keeper keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .flush      (slots_flush[c]),
      .init_valid (keeper_init[c]),
      .init_count (slot_msg_slot),
      .free_valid (keeper_free[c]),
      .free_slot  (slot_msg_slot),
      .pop        (keeper_pop[c]),
      .head_slot  (head_slot[c]),
      .head_valid (head_valid[c]),
      .count      (slot_counts[c]),
      .enq_err    ()
    );
  end

endmodule

// File: hdl/desc_result.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module desc_result (
  input  logic                 clk,
  input  logic                 rst_r,
  input  logic                 alloc_valid,
  input  sched_pkg::if_id_t    alloc_if,
  input  sched_pkg::core_id_t  alloc_core,
  input  sched_pkg::slot_t     alloc_slot,
  input  sched_pkg::hash_t     alloc_hash,
  input  logic                 alloc_drop,
  output logic                 alloc_ready,
  output logic                 desc_valid,
  input  logic                 desc_ready,
  output sched_pkg::if_id_t    desc_if,
  output sched_pkg::core_id_t  desc_core,
  output sched_pkg::slot_t     desc_slot,
  output sched_pkg::hash_t     desc_hash,
  output logic                 desc_drop,
  output sched_pkg::apb_data_t drop_counts [`SCHED_IF_COUNT]
);

  import sched_pkg::*;

  logic load;

  // Room when empty or when the current entry leaves this cycle
  assign alloc_ready = !desc_valid || desc_ready;
  assign load        = alloc_valid && alloc_ready;

  always_ff @(posedge clk) begin
    if (rst_r) begin
      desc_valid <= 1'b0;
    end else if (load) begin
      desc_valid <= 1'b1;
    end else if (desc_ready) begin
      desc_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      desc_if   <= alloc_if;
      desc_core <= alloc_core;
      desc_slot <= alloc_slot;
      desc_hash <= alloc_hash;
      desc_drop <= alloc_drop;
    end
  end

  // Drop statistics per interface
  always_ff @(posedge clk) begin
    if (rst_r) begin
      for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
        drop_counts[i] <= '0;
      end
    end else if (load && alloc_drop) begin
      drop_counts[alloc_if] <= drop_counts[alloc_if] + apb_data_t'(1);
    end
  end

endmodule

// File: hdl/rx_scheduler.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module rx_scheduler (
  input  logic                        clk,
  input  logic                        rst_r,
  input  logic                        psel,
  input  logic                        penable,
  input  logic                        pwrite,
  input  sched_pkg::apb_addr_t        paddr,
  input  sched_pkg::apb_data_t        pwdata,
  output sched_pkg::apb_data_t        prdata,
  output logic                        pready,
  output logic                        pslverr,
  input  logic [`SCHED_IF_COUNT-1:0]  hash_valid,
  input  sched_pkg::hash_t            hash [`SCHED_IF_COUNT],
  output logic [`SCHED_IF_COUNT-1:0]  hash_ready,
  input  sched_pkg::line_count_t      line_count [`SCHED_IF_COUNT],
  input  logic                        slot_msg_valid,
  input  sched_pkg::slot_msg_e        slot_msg_type,
  input  sched_pkg::core_id_t         slot_msg_core,
  input  sched_pkg::slot_t            slot_msg_slot,
  output logic                        desc_valid,
  input  logic                        desc_ready,
  output sched_pkg::if_id_t           desc_if,
  output sched_pkg::core_id_t         desc_core,
  output sched_pkg::slot_t            desc_slot,
  output sched_pkg::hash_t            desc_hash,
  output logic                        desc_drop
);

  import sched_pkg::*;

  core_mask_t  enabled_cores;
  core_mask_t  income_cores;
  core_mask_t  slots_flush;
  line_count_t drop_limit;
  slot_t       slot_counts [`SCHED_CORE_COUNT];
  apb_data_t   drop_counts [`SCHED_IF_COUNT];

  logic        alloc_valid;
  logic        alloc_ready;
  if_id_t      alloc_if;
  core_id_t    alloc_core;
  slot_t       alloc_slot;
  hash_t       alloc_hash;
  logic        alloc_drop;

  // Host register file
  sched_host_regs dec0 (
    .clk           (clk),
    .rst_r         (rst_r),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .slot_counts   (slot_counts),
    .drop_counts   (drop_counts),
    .enabled_cores (enabled_cores),
    .income_cores  (income_cores),
    .slots_flush   (slots_flush),
    .drop_limit    (drop_limit)
  );

  // Arbitration and slot allocation
  desc_allocator exe0 (
    .clk            (clk),
    .rst_r          (rst_r),
    .hash_valid     (hash_valid),
    .hash           (hash),
    .hash_ready     (hash_ready),
    .line_count     (line_count),
    .slot_msg_valid (slot_msg_valid),
    .slot_msg_type  (slot_msg_type),
    .slot_msg_core  (slot_msg_core),
    .slot_msg_slot  (slot_msg_slot),
    .enabled_cores  (enabled_cores),
    .income_cores   (income_cores),
    .slots_flush    (slots_flush),
    .drop_limit     (drop_limit),
    .slot_counts    (slot_counts),
    .alloc_valid    (alloc_valid),
    .alloc_if       (alloc_if),
    .alloc_core     (alloc_core),
    .alloc_slot     (alloc_slot),
    .alloc_hash     (alloc_hash),
    .alloc_drop     (alloc_drop),
    .alloc_ready    (alloc_ready)
  );

  // Descriptor output register and drop statistics
  desc_result res0 (
    .clk         (clk),
    .rst_r       (rst_r),
    .alloc_valid (alloc_valid),
    .alloc_if    (alloc_if),
    .alloc_core  (alloc_core),
    .alloc_slot  (alloc_slot),
    .alloc_hash  (alloc_hash),
    .alloc_drop  (alloc_drop),
    .alloc_ready (alloc_ready),
    .desc_valid  (desc_valid),
    .desc_ready  (desc_ready),
    .desc_if     (desc_if),
    .desc_core   (desc_core),
    .desc_slot   (desc_slot),
    .desc_hash   (desc_hash),
    .desc_drop   (desc_drop),
    .drop_counts (drop_counts)
  );

endmodule

// File: hdl/sched_defines.svh
`ifndef SCHED_DEFINES_SVH
`define SCHED_DEFINES_SVH

// Structure of the scheduler
`define SCHED_IF_COUNT             3
`define SCHED_CORE_COUNT           4
`define SCHED_SLOT_COUNT           8

// Lowest flow hash bit of the core select field
`define SCHED_HASH_SEL_OFFSET      14

// Receive buffer fill level width
`define SCHED_LINES_WIDTH          13

// APB register map, per-core and per-interface blocks use a 4 byte stride
`define SCHED_ADDR_ENABLE          8'h00
`define SCHED_ADDR_INCOME          8'h04
`define SCHED_ADDR_FLUSH           8'h08
`define SCHED_ADDR_DROP_LIMIT      8'h0C
`define SCHED_ADDR_SLOT_COUNT_BASE 8'h10
`define SCHED_ADDR_DROP_COUNT_BASE 8'h20

`define SCHED_DROP_LIMIT_RESET     13'h0E00
`define SCHED_UNMAPPED_DATA        32'hFEFE_FEFE

`endif

// File: hdl/sched_host_regs.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module sched_host_regs (
  input  logic                    clk,
  input  logic                    rst_r,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  sched_pkg::apb_addr_t    paddr,
  input  sched_pkg::apb_data_t    pwdata,
  output sched_pkg::apb_data_t    prdata,
  output logic                    pready,
  output logic                    pslverr,
  input  sched_pkg::slot_t        slot_counts [`SCHED_CORE_COUNT],
  input  sched_pkg::apb_data_t    drop_counts [`SCHED_IF_COUNT],
  output sched_pkg::core_mask_t   enabled_cores,
  output sched_pkg::core_mask_t   income_cores,
  output sched_pkg::core_mask_t   slots_flush,
  output sched_pkg::line_count_t  drop_limit
);

  import sched_pkg::*;

  logic       wr_en;
  core_mask_t wr_mask;

  // Zero wait state slave
  assign pready  = 1'b1;
  assign pslverr = 1'b0;

  // Write lands at the edge closing the access phase
  assign wr_en   = psel && penable && pwrite;
  assign wr_mask = pwdata[`SCHED_CORE_COUNT-1:0];

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enabled_cores <= '0;
      income_cores  <= '0;
      slots_flush   <= '0;
      drop_limit    <= `SCHED_DROP_LIMIT_RESET;
    end else begin
      // Flush is a single cycle strobe
      slots_flush <= '0;
      if (wr_en) begin
        case (paddr)
          `SCHED_ADDR_ENABLE: begin
            enabled_cores <= wr_mask;
            // A core being disabled stops taking traffic
            income_cores  <= income_cores & wr_mask;
          end
          `SCHED_ADDR_INCOME: begin
            income_cores <= wr_mask & enabled_cores;
          end
          `SCHED_ADDR_FLUSH: begin
            slots_flush <= wr_mask;
          end
          `SCHED_ADDR_DROP_LIMIT: begin
            drop_limit <= pwdata[`SCHED_LINES_WIDTH-1:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

  // Combinational readback during the access phase
  always_comb begin
    prdata = `SCHED_UNMAPPED_DATA;
    case (paddr)
      `SCHED_ADDR_ENABLE:     prdata = apb_data_t'(enabled_cores);
      `SCHED_ADDR_INCOME:     prdata = apb_data_t'(income_cores);
      `SCHED_ADDR_FLUSH:      prdata = apb_data_t'(slots_flush);
      `SCHED_ADDR_DROP_LIMIT: prdata = apb_data_t'(drop_limit);
      default: begin
        for (int c = 0; c < `SCHED_CORE_COUNT; c++) begin
          if (paddr == apb_addr_t'(`SCHED_ADDR_SLOT_COUNT_BASE + 4 * c)) begin
            prdata = apb_data_t'(slot_counts[c]);
          end
        end
        for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
          if (paddr == apb_addr_t'(`SCHED_ADDR_DROP_COUNT_BASE + 4 * i)) begin
            prdata = drop_counts[i];
          end
        end
      end
    endcase
  end

endmodule

// File: hdl/sched_pkg.sv
`include "sched_defines.svh"

package sched_pkg;

  // Flow hash as computed upstream
  typedef logic [31:0] hash_t;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0] core_id_t;
  typedef logic [1:0] if_id_t;

  // Wide enough for slot numbers 1..8 and counts 0..8
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;

  typedef logic [`SCHED_CORE_COUNT-1:0] core_mask_t;

  typedef logic [`SCHED_LINES_WIDTH-1:0] line_count_t;

  // Slot message from a core
  typedef enum logic {
    SLOT_FREE = 1'b0,
    SLOT_INIT = 1'b1
  } slot_msg_e;

  // APB host port
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

endpackage

// File: hdl/slot_keeper.sv
`timescale 1ns/1ps
`include "sched_defines.svh"

module slot_keeper (
  input  logic             clk,
  input  logic             rst_r,
  input  logic             flush,
  input  logic             init_valid,
  input  sched_pkg::slot_t init_count,
  input  logic             free_valid,
  input  sched_pkg::slot_t free_slot,
  input  logic             pop,
  output sched_pkg::slot_t head_slot,
  output logic             head_valid,
  output sched_pkg::slot_t count,
  output logic             enq_err
);

  import sched_pkg::*;

  localparam int PTR_W = $clog2(`SCHED_SLOT_COUNT);

  slot_t            mem [`SCHED_SLOT_COUNT];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  slot_t            init_n;
  logic             full;
  logic             do_pop;
  logic             do_push;

  assign full       = (count == slot_t'(`SCHED_SLOT_COUNT));
  assign head_valid = (count != '0);
  assign head_slot  = mem[rd_ptr];

  // Init request is clipped to the pool size
  assign init_n = (init_count > slot_t'(`SCHED_SLOT_COUNT)) ?
                  slot_t'(`SCHED_SLOT_COUNT) : init_count;

  // Flush and init take the whole list, so they win over push and pop
  assign do_pop  = pop && head_valid && !flush && !init_valid;
  assign do_push = free_valid && !flush && !init_valid && (!full || do_pop);

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= init_n[PTR_W-1:0];
      count  <= init_n;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      enq_err <= 1'b0;
    end else begin
      enq_err <= free_valid && !flush && !init_valid && full && !do_pop;
    end
  end

  // Init fills slots 1..N from the head
  always_ff @(posedge clk) begin
    if (init_valid && !flush) begin
      for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (do_push) begin
      mem[wr_ptr] <= free_slot;
    end
  end

endmodule

// File: sim.f
+incdir+hdl
hdl/sched_pkg.sv
hdl/sched_host_regs.sv
hdl/slot_keeper.sv
hdl/desc_allocator.sv
hdl/desc_result.sv
hdl/rx_scheduler.sv
dv/rx_scheduler_props.sv
dv/rx_scheduler_tb.sv
